// ==== vlog.f ====
+incdir+.
vec_pkg.sv
vreg_if.sv
vec_sequencer.sv
vreg_file.sv
vec_lanes.sv
vec_unit_top.sv
vec_asserts.sv
tb_vec_unit.sv

// ==== Makefile ====
# Verilator build and run of the vector slice testbench
VERILATOR ?= verilator
TOP       ?= tb_vec_unit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_vec_unit.sv ====
// self-checking testbench that runs directed commands on the vector slice against a byte model
`timescale 1ns/1ps
`default_nettype none

`include "vec_config.svh"

module tb_vec_unit;
  import vec_pkg::*;

  // well above twice the summed length of the tests
  localparam int MAX_CYCLES = 3000;
  localparam int DONE_WAIT  = 200;

  logic     CLK;
  logic     nRST;
  logic     start;
  vop_t     op;
  sew_t     sew;
  logic     vm;
  reg_idx_t vd;
  reg_idx_t vs1;
  reg_idx_t vs2;
  vl_t      vl;
  elem_t    scalar;
  logic     busy;
  logic     done;
  reg_idx_t rd_vreg;
  offset_t  rd_idx;
  sew_t     rd_sew;
  elem_t    rd_data;

  // byte image of the register file
  logic [7:0] model_mem [`VEC_NUM_REGS][`VEC_VLEN_BYTES];
  int seed      = 32'hd23e;
  int checks    = 0;
  int errors    = 0;
  int cycle_cnt = 0;

  vec_unit_top dut_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .start   (start),
    .op      (op),
    .sew     (sew),
    .vm      (vm),
    .vd      (vd),
    .vs1     (vs1),
    .vs2     (vs2),
    .vl      (vl),
    .scalar  (scalar),
    .busy    (busy),
    .done    (done),
    .rd_vreg (rd_vreg),
    .rd_idx  (rd_idx),
    .rd_sew  (rd_sew),
    .rd_data (rd_data)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic int bytes_per_elem(sew_t w);
    case (w)
      SEW8:    return 1;
      SEW16:   return 2;
      default: return 4;
    endcase
  endfunction

  function automatic elem_t width_mask(sew_t w);
    case (w)
      SEW8:    return 32'h0000_00ff;
      SEW16:   return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // element i sits at byte (i % epr) * bpe of register base + i / epr
  function automatic elem_t model_read(int base, int idx, sew_t w);
    int    bpe;
    int    epr;
    int    r;
    int    b;
    elem_t v;
    bpe = bytes_per_elem(w);
    epr = `VEC_VLEN_BYTES / bpe;
    r   = (base + idx / epr) % `VEC_NUM_REGS;
    b   = (idx % epr) * bpe;
    v   = '0;
    for (int k = 0; k < bpe; k++) begin
      v[8*k +: 8] = model_mem[r][b + k];
    end
    return v;
  endfunction

  task automatic model_write(int base, int idx, sew_t w, elem_t v);
    int bpe;
    int epr;
    int r;
    int b;
    bpe = bytes_per_elem(w);
    epr = `VEC_VLEN_BYTES / bpe;
    r   = (base + idx / epr) % `VEC_NUM_REGS;
    b   = (idx % epr) * bpe;
    for (int k = 0; k < bpe; k++) begin
      model_mem[r][b + k] = v[8*k +: 8];
    end
  endtask

  // vd = vs2 op vs1 cut to the element width
  function automatic elem_t expected_result(vop_t o, elem_t a, elem_t b, elem_t s, sew_t w);
    elem_t r;
    case (o)
      VOP_ADD: r = b + a;
      VOP_SUB: r = b - a;
      VOP_AND: r = b & a;
      VOP_OR:  r = b | a;
      VOP_XOR: r = b ^ a;
      default: r = s;
    endcase
    return r & width_mask(w);
  endfunction

  task automatic model_exec(vop_t o, sew_t w, logic m, int d, int s1, int s2, int n, elem_t s);
    elem_t a;
    elem_t b;
    for (int i = 0; i < n; i++) begin
      // mask bit i of register 0
      if (m || model_mem[0][i / 8][i % 8]) begin
        a = model_read(s1, i, w);
        b = model_read(s2, i, w);
        model_write(d, i, w, expected_result(o, a, b, s, w));
      end
    end
  endtask

  task automatic check(string name, elem_t expected, elem_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic wait_for_done(string name, output int cycles);
    cycles = 0;
    while (done !== 1'b1 && cycles < DONE_WAIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (done !== 1'b1) begin
      errors++;
      $display("%s: no done pulse within %0d cycles", name, DONE_WAIT);
    end
  endtask

  // one command with its latency check and model update
  task automatic run_cmd(string name, vop_t o, sew_t w, logic m, int d, int s1, int s2,
                         int n, elem_t s);
    int cycles;
    @(negedge CLK);
    op     = o;
    sew    = w;
    vm     = m;
    vd     = reg_idx_t'(d);
    vs1    = reg_idx_t'(s1);
    vs2    = reg_idx_t'(s2);
    vl     = vl_t'(n);
    scalar = s;
    start  = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    wait_for_done(name, cycles);
    check({name, " latency"}, elem_t'((n + 1) / 2 + 2), elem_t'(cycles));
    model_exec(o, w, m, d, s1, s2, n, s);
  endtask

  task automatic check_elems(string name, int base, sew_t w, int count);
    elem_t got;
    for (int i = 0; i < count; i++) begin
      @(negedge CLK);
      rd_vreg = reg_idx_t'(base);
      rd_idx  = offset_t'(i);
      rd_sew  = w;
      @(posedge CLK);
      got = rd_data;
      check($sformatf("%s v%0d[%0d]", name, base, i), model_read(base, i, w), got);
    end
  endtask

  task automatic test_reset_zero();
    int regs [3] = '{0, 13, 31};
    foreach (regs[k]) begin
      check_elems("reset8", regs[k], SEW8, 16);
      check_elems("reset16", regs[k], SEW16, 8);
      check_elems("reset32", regs[k], SEW32, 4);
    end
  endtask

  task automatic test_broadcast16();
    run_cmd("pre_v4", VOP_MVX, SEW8, 1'b1, 4, 0, 0, 32, 32'h0000_005a);
    run_cmd("mvx16", VOP_MVX, SEW16, 1'b1, 4, 0, 0, 13, $random(seed));
    check_elems("mvx16", 4, SEW16, 16);
  endtask

  task automatic test_add_sub32();
    run_cmd("pre_v8", VOP_MVX, SEW32, 1'b1, 8, 0, 0, 7, $random(seed));
    run_cmd("pre_v8", VOP_MVX, SEW32, 1'b1, 8, 0, 0, 3, 32'hffff_fff0);
    run_cmd("pre_v12", VOP_MVX, SEW32, 1'b1, 12, 0, 0, 7, $random(seed));
    run_cmd("pre_v12", VOP_MVX, SEW32, 1'b1, 12, 0, 0, 2, 32'h0000_0031);
    run_cmd("add32", VOP_ADD, SEW32, 1'b1, 16, 8, 12, 7, '0);
    check_elems("add32", 16, SEW32, 8);
    // destination is also the vs2 source
    run_cmd("sub32", VOP_SUB, SEW32, 1'b1, 8, 12, 8, 5, '0);
    check_elems("sub32", 8, SEW32, 8);
    run_cmd("vl0", VOP_ADD, SEW32, 1'b1, 16, 12, 12, 0, '0);
    check_elems("vl0", 16, SEW32, 8);
  endtask

  task automatic test_logic8();
    run_cmd("pre_v20", VOP_MVX, SEW8, 1'b1, 20, 0, 0, 48, $random(seed));
    run_cmd("pre_v20", VOP_MVX, SEW16, 1'b1, 20, 0, 0, 11, $random(seed));
    run_cmd("pre_v20", VOP_MVX, SEW8, 1'b1, 20, 0, 0, 7, $random(seed));
    run_cmd("pre_v24", VOP_MVX, SEW8, 1'b1, 24, 0, 0, 48, $random(seed));
    run_cmd("pre_v24", VOP_MVX, SEW32, 1'b1, 24, 0, 0, 5, $random(seed));
    run_cmd("pre_v24", VOP_MVX, SEW8, 1'b1, 24, 0, 0, 33, $random(seed));
    run_cmd("and8", VOP_AND, SEW8, 1'b1, 28, 20, 24, 40, '0);
    check_elems("and8", 28, SEW8, 48);
    run_cmd("or8", VOP_OR, SEW8, 1'b1, 28, 20, 24, 40, '0);
    check_elems("or8", 28, SEW8, 48);
    run_cmd("xor8", VOP_XOR, SEW8, 1'b1, 28, 28, 24, 40, '0);
    check_elems("xor8", 28, SEW8, 48);
  endtask

  task automatic test_masked_add();
    // mask pattern a5 with the first two bytes 3c
    run_cmd("pre_v0", VOP_MVX, SEW8, 1'b1, 0, 0, 0, 16, 32'h0000_00a5);
    run_cmd("pre_v0", VOP_MVX, SEW8, 1'b1, 0, 0, 0, 2, 32'h0000_003c);
    run_cmd("madd16", VOP_ADD, SEW16, 1'b0, 14, 20, 24, 20, '0);
    check_elems("madd16", 14, SEW16, 24);
    run_cmd("mmvx32", VOP_MVX, SEW32, 1'b0, 18, 0, 0, 9, $random(seed));
    check_elems("mmvx32", 18, SEW32, 12);
  endtask

  task automatic test_start_while_busy();
    int cycles;
    int extra;
    @(negedge CLK);
    op     = VOP_ADD;
    sew    = SEW8;
    vm     = 1'b1;
    vd     = reg_idx_t'(6);
    vs1    = reg_idx_t'(20);
    vs2    = reg_idx_t'(24);
    vl     = vl_t'(10);
    scalar = '0;
    start  = 1'b1;
    @(negedge CLK);
    if (busy !== 1'b1) begin
      errors++;
      $display("start_busy: busy was low one cycle after start");
    end
    // second command while busy is dropped
    op     = VOP_MVX;
    vd     = reg_idx_t'(7);
    scalar = 32'h0000_00c3;
    @(negedge CLK);
    start = 1'b0;
    wait_for_done("start_busy", cycles);
    check("start_busy latency", elem_t'((10 + 1) / 2 + 2), elem_t'(cycles + 1));
    extra = 0;
    repeat (12) begin
      @(negedge CLK);
      if (done === 1'b1) begin
        extra++;
      end
    end
    check("start_busy extra done", '0, elem_t'(extra));
    model_exec(VOP_ADD, SEW8, 1'b1, 6, 20, 24, 10, '0);
    check_elems("start_busy", 6, SEW8, 16);
    check_elems("start_busy", 7, SEW8, 16);
  endtask

  initial begin
    nRST    = 1'b0;
    start   = 1'b0;
    op      = VOP_ADD;
    sew     = SEW8;
    vm      = 1'b1;
    vd      = '0;
    vs1     = '0;
    vs2     = '0;
    vl      = '0;
    scalar  = '0;
    rd_vreg = '0;
    rd_idx  = '0;
    rd_sew  = SEW8;
    foreach (model_mem[r, b]) begin
      model_mem[r][b] = 8'h00;
    end
    repeat (8) @(negedge CLK);
    nRST = 1'b1;

    test_reset_zero();
    test_broadcast16();
    test_add_sub32();
    test_logic8();
    test_masked_add();
    test_start_while_busy();

    $display("checks %0d errors %0d assertion failures %0d", checks, errors,
             dut_i.asserts_i.fail_count);
    if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vec_asserts.sv ====
// concurrent checks on busy and done that bind attaches to the top level
`timescale 1ns/1ps
`default_nettype none

module vec_asserts (
  input wire logic CLK,
  input wire logic nRST,
  input wire logic busy,
  input wire logic done
);

  int fail_count = 0;

  done_single_cycle: assert property (@(posedge CLK) disable iff (!nRST) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      fail_count++;
    end

  // busy drops in the same cycle done rises
  no_busy_with_done: assert property (@(posedge CLK) disable iff (!nRST) done |-> !busy)
    else begin
      $error("busy high while done is pulsed");
      fail_count++;
    end

  idle_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> (!busy && !done))
    else begin
      $error("busy or done high right after reset release");
      fail_count++;
    end

endmodule

bind vec_unit_top vec_asserts asserts_i (
  .CLK  (CLK),
  .nRST (nRST),
  .busy (busy),
  .done (done)
);

`default_nettype wire

// ==== vec_unit_top.sv ====
// top of the two-lane vector slice, command strobe in and element read port out
`timescale 1ns/1ps
`default_nettype none

module vec_unit_top (
  input  wire logic              CLK,
  input  wire logic              nRST,
  input  wire logic              start,
  input  wire vec_pkg::vop_t     op,
  input  wire vec_pkg::sew_t     sew,
  input  wire logic              vm,
  input  wire vec_pkg::reg_idx_t vd,
  input  wire vec_pkg::reg_idx_t vs1,
  input  wire vec_pkg::reg_idx_t vs2,
  input  wire vec_pkg::vl_t      vl,
  input  wire vec_pkg::elem_t    scalar,
  output logic                   busy,
  output logic                   done,
  input  wire vec_pkg::reg_idx_t rd_vreg,
  input  wire vec_pkg::offset_t  rd_idx,
  input  wire vec_pkg::sew_t     rd_sew,
  output vec_pkg::elem_t         rd_data
);

  vreg_if vif ();

  vec_sequencer seq_i (
    .CLK    (CLK),
    .nRST   (nRST),
    .start  (start),
    .op     (op),
    .sew    (sew),
    .vm     (vm),
    .vd     (vd),
    .vs1    (vs1),
    .vs2    (vs2),
    .vl     (vl),
    .scalar (scalar),
    .busy   (busy),
    .done   (done),
    .vif    (vif.seq)
  );

  vreg_file rf_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .vif     (vif.rf),
    .rd_vreg (rd_vreg),
    .rd_idx  (rd_idx),
    .rd_sew  (rd_sew),
    .rd_data (rd_data)
  );

  vec_lanes lanes_i (
    .CLK  (CLK),
    .nRST (nRST),
    .vif  (vif.lane)
  );

endmodule

`default_nettype wire

// ==== vec_lanes.sv ====
// two registered execution lanes, compute one element pair per cycle for write-back
`timescale 1ns/1ps
`default_nettype none

module vec_lanes (
  input  wire logic CLK,
  input  wire logic nRST,
  vreg_if.lane      vif
);
  import vec_pkg::*;

  elem_t [NUM_LANES-1:0] result;

  // subtract is vs2 minus vs1
  function automatic elem_t lane_alu(vop_t f_op, elem_t a, elem_t b, elem_t s, sew_t w);
    elem_t r;
    case (f_op)
      VOP_ADD: r = b + a;
      VOP_SUB: r = b - a;
      VOP_AND: r = b & a;
      VOP_OR:  r = b | a;
      VOP_XOR: r = b ^ a;
      default: r = s;
    endcase
    // truncate to the element width
    if (w == SEW8) begin
      r = elem_t'(r[7:0]);
    end else if (w == SEW16) begin
      r = elem_t'(r[15:0]);
    end
    return r;
  endfunction

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      result[l] = lane_alu(vif.op, vif.vs1_data[l], vif.vs2_data[l], vif.scalar, vif.sew);
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vif.wen <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        vif.wen[l] <= vif.lane_en[l] && !vif.masked_off[l];
      end
    end
  end

  always_ff @(posedge CLK) begin
    vif.w_data   <= result;
    vif.w_vd     <= vif.vd;
    vif.w_offset <= vif.rd_offset;
    vif.w_sew    <= vif.sew;
  end

endmodule

`default_nettype wire

// ==== vreg_file.sv ====
// vector register file with width-aware element addressing, two operand lanes and a read port
`timescale 1ns/1ps
`default_nettype none

`include "vec_config.svh"

module vreg_file (
  input  wire logic              CLK,
  input  wire logic              nRST,
  vreg_if.rf                     vif,
  input  wire vec_pkg::reg_idx_t rd_vreg,
  input  wire vec_pkg::offset_t  rd_idx,
  input  wire vec_pkg::sew_t     rd_sew,
  output vec_pkg::elem_t         rd_data
);
  import vec_pkg::*;

  typedef logic [$clog2(`VEC_VLEN_BYTES)-1:0] byte_pos_t;

  vreg_t [`VEC_NUM_REGS-1:0]     registers;
  offset_t [`VEC_LANES-1:0]      rd_off;
  offset_t [`VEC_LANES-1:0]      wr_off;
  reg_idx_t [`VEC_LANES-1:0]     wr_reg;
  byte_pos_t [`VEC_LANES-1:0]    wr_byte;

  // register step within the group, 16, 8 or 4 elements per register
  function automatic reg_idx_t elem_reg(reg_idx_t base, offset_t idx, sew_t w);
    reg_idx_t step;
    case (w)
      SEW32:   step = reg_idx_t'(idx[6:2]);
      SEW16:   step = reg_idx_t'(idx[6:3]);
      default: step = reg_idx_t'(idx[6:4]);
    endcase
    // wraps modulo the register count
    return base + step;
  endfunction

  // first byte of the element inside its register
  function automatic byte_pos_t elem_byte(offset_t idx, sew_t w);
    byte_pos_t pos;
    case (w)
      SEW32:   pos = {idx[1:0], 2'b00};
      SEW16:   pos = {idx[2:0], 1'b0};
      default: pos = idx[3:0];
    endcase
    return pos;
  endfunction

  // narrow elements come back zero-extended
  function automatic elem_t read_elem(vreg_t r, byte_pos_t pos, sew_t w);
    elem_t e;
    case (w)
      SEW32:   e = r[pos +: 4];
      SEW16:   e = elem_t'(r[pos +: 2]);
      default: e = elem_t'(r[pos]);
    endcase
    return e;
  endfunction

  always_comb begin
    for (int l = 0; l < `VEC_LANES; l++) begin
      rd_off[l]  = vif.rd_offset + offset_t'(l);
      wr_off[l]  = vif.w_offset + offset_t'(l);
      wr_reg[l]  = elem_reg(vif.w_vd, wr_off[l], vif.w_sew);
      wr_byte[l] = elem_byte(wr_off[l], vif.w_sew);
    end
  end

  // operand reads and mask bits from register 0
  always_comb begin
    for (int l = 0; l < `VEC_LANES; l++) begin
      vif.vs1_data[l] = read_elem(registers[elem_reg(vif.vs1, rd_off[l], vif.sew)],
                                  elem_byte(rd_off[l], vif.sew), vif.sew);
      vif.vs2_data[l] = read_elem(registers[elem_reg(vif.vs2, rd_off[l], vif.sew)],
                                  elem_byte(rd_off[l], vif.sew), vif.sew);
      vif.mask[l]     = registers[0][rd_off[l][6:3]][rd_off[l][2:0]];
    end
  end

  assign rd_data = read_elem(registers[elem_reg(rd_vreg, rd_idx, rd_sew)],
                             elem_byte(rd_idx, rd_sew), rd_sew);

  // wen already carries the vl and mask decision
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      registers <= '0;
    end else begin
      for (int l = 0; l < `VEC_LANES; l++) begin
        if (vif.wen[l]) begin
          case (vif.w_sew)
            SEW32:   registers[wr_reg[l]][wr_byte[l] +: 4] <= vif.w_data[l];
            SEW16:   registers[wr_reg[l]][wr_byte[l] +: 2] <= vif.w_data[l][15:0];
            default: registers[wr_reg[l]][wr_byte[l]]      <= vif.w_data[l][7:0];
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== vec_sequencer.sv ====
// command sequencer, captures a command on start and walks element pairs through the lanes
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
  input  wire logic              CLK,
  input  wire logic              nRST,
  input  wire logic              start,
  input  wire vec_pkg::vop_t     op,
  input  wire vec_pkg::sew_t     sew,
  input  wire logic              vm,
  input  wire vec_pkg::reg_idx_t vd,
  input  wire vec_pkg::reg_idx_t vs1,
  input  wire vec_pkg::reg_idx_t vs2,
  input  wire vec_pkg::vl_t      vl,
  input  wire vec_pkg::elem_t    scalar,
  output logic                   busy,
  output logic                   done,
  vreg_if.seq                    vif
);
  import vec_pkg::*;

  seq_state_t state;
  logic       drain_cnt;
  vl_t        vl_q;
  logic       vm_q;
  offset_t    rd_offset;
  logic       accept;
  logic       last_pair;

  // starts while busy are dropped
  assign accept    = start && (state == SEQ_IDLE);
  assign last_pair = (vl_t'(rd_offset) + vl_t'(2)) >= vl_q;
  assign busy      = (state != SEQ_IDLE);

  assign vif.rd_offset = rd_offset;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state     <= SEQ_IDLE;
      drain_cnt <= 1'b0;
      rd_offset <= '0;
      vl_q      <= '0;
      vm_q      <= 1'b1;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (accept) begin
            vl_q      <= vl;
            vm_q      <= vm;
            rd_offset <= '0;
            // empty command goes straight to the two drain cycles
            state     <= (vl == '0) ? SEQ_DRAIN : SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          rd_offset <= rd_offset + offset_t'(2);
          if (last_pair) begin
            state <= SEQ_DRAIN;
          end
        end
        SEQ_DRAIN: begin
          // one cycle in the lanes, one cycle for the write
          drain_cnt <= !drain_cnt;
          if (drain_cnt) begin
            done  <= 1'b1;
            state <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // command payload
  always_ff @(posedge CLK) begin
    if (accept) begin
      vif.op     <= op;
      vif.sew    <= sew;
      vif.vd     <= vd;
      vif.vs1    <= vs1;
      vif.vs2    <= vs2;
      vif.scalar <= scalar;
    end
  end

  // lane i is live while its index is below vl
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      vif.lane_en[i]    = (state == SEQ_ISSUE) && ((vl_t'(rd_offset) + vl_t'(i)) < vl_q);
      vif.masked_off[i] = !vm_q && !vif.mask[i];
    end
  end

endmodule

`default_nettype wire

// ==== vreg_if.sv ====
// operand read and write-back bundle between sequencer, register file and lanes
`timescale 1ns/1ps
`default_nettype none

`include "vec_config.svh"

interface vreg_if;
  import vec_pkg::*;

  // read side, rd_offset is the element index of lane 0
  sew_t                       sew;
  reg_idx_t                   vs1;
  reg_idx_t                   vs2;
  offset_t                    rd_offset;
  elem_t [`VEC_LANES-1:0]     vs1_data;
  elem_t [`VEC_LANES-1:0]     vs2_data;
  logic [`VEC_LANES-1:0]      mask;

  // issue qualifiers and command bundle for the lanes
  logic [`VEC_LANES-1:0]      lane_en;
  logic [`VEC_LANES-1:0]      masked_off;
  vop_t                       op;
  elem_t                      scalar;
  reg_idx_t                   vd;

  // write-back
  logic [`VEC_LANES-1:0]      wen;
  elem_t [`VEC_LANES-1:0]     w_data;
  reg_idx_t                   w_vd;
  offset_t                    w_offset;
  sew_t                       w_sew;

  modport seq (
    output sew, vs1, vs2, rd_offset, lane_en, masked_off, op, scalar, vd,
    input  mask
  );

  modport rf (
    input  sew, vs1, vs2, rd_offset, wen, w_data, w_vd, w_offset, w_sew,
    output vs1_data, vs2_data, mask
  );

  modport lane (
    input  sew, rd_offset, lane_en, masked_off, op, scalar, vd, vs1_data, vs2_data,
    output wen, w_data, w_vd, w_offset, w_sew
  );

endinterface

`default_nettype wire

// ==== vec_pkg.sv ====
// shared enums and data types of the vector slice, imported by every block
`default_nettype none

`include "vec_config.svh"

package vec_pkg;

  localparam int NUM_LANES = `VEC_LANES;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [2:0] {
    VOP_ADD = 3'd0,
    VOP_SUB = 3'd1,
    VOP_AND = 3'd2,
    VOP_OR  = 3'd3,
    VOP_XOR = 3'd4,
    VOP_MVX = 3'd5
  } vop_t;

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_ISSUE = 2'd1,
    SEQ_DRAIN = 2'd2
  } seq_state_t;

  // byte 0 is the lowest byte of the register
  typedef logic [`VEC_VLEN_BYTES-1:0][7:0] vreg_t;
  typedef logic [$clog2(`VEC_MAX_VL)-1:0] offset_t;
  typedef logic [$clog2(`VEC_MAX_VL):0] vl_t;
  typedef logic [`VEC_ELEN-1:0] elem_t;
  typedef logic [$clog2(`VEC_NUM_REGS)-1:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== vec_config.svh ====
// sizing macros for the vector slice, include before any sized type or storage
`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

// register file geometry
`define VEC_NUM_REGS 32
`define VEC_VLEN_BYTES 16

// widest element, also the lane datapath width
`define VEC_ELEN 32

// eight registers of bytes
`define VEC_MAX_VL 128

// element pairs handled per cycle
`define VEC_LANES 2

`endif
